/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_smpc_pad_ports
FILELIST  ?= smpc_pad_ports.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** PASSED ***

SOURCES := $(wildcard include/*.svh verilog/*.sv verif/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/smpc_pad_cfg.svh */
`ifndef SMPC_PAD_CFG_SVH
`define SMPC_PAD_CFG_SVH

// Port data / direction register width
// TH, TR, TL and the data nibble
`define SMPC_PAD_PIN_W 7

// Data nibble on the low pins
`define SMPC_PAD_DATA_W 4

// Handshake step counter
// Needs to hold step 16 for the 3D pad
`define SMPC_PAD_STEP_W 5

// Pad button word and analog axis
`define SMPC_PAD_BTN_W 16
`define SMPC_PAD_AXIS_W 8

// Racing wheel ID, sent as B then F
`define SMPC_PAD_ID_WHEEL_HI 4'hB
`define SMPC_PAD_ID_WHEEL_LO 4'hF

// Analog pad ID nibbles
`define SMPC_PAD_ID_MISSION 4'h5
`define SMPC_PAD_ID_3D 4'h6

// Signed axis to unsigned
// Sign bit of the high nibble is inverted
`define SMPC_PAD_AXIS_FLIP 4'h8

`endif

/* smpc_pad_ports.f */
+incdir+include
verilog/smpc_pad_pkg.sv
verilog/pad_handshake.sv
verilog/pad_pin_mux.sv
verilog/smpc_pad_ports.sv
verif/tb_clock_gen.sv
verif/tb_smpc_pad_ports.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD    = 100,
	parameter int RST_CYC   = 4,
	parameter int DRIVE_DLY = 5
) (
	output logic CLK,
	output logic RST_N
);

	// Free running clock, starts low
	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// Reset low for RST_CYC rising edges
	// released off the edge like any other input
	initial begin
		RST_N = 1'b0;
		repeat (RST_CYC) @(posedge CLK);
		#DRIVE_DLY;
		RST_N = 1'b1;
	end

endmodule

/* verif/tb_smpc_pad_ports.sv */
`timescale 1ns/1ps

`include "smpc_pad_cfg.svh"

module tb_smpc_pad_ports;
	import smpc_pad_pkg::*;

	localparam int DRIVE_DLY = 5;

	// Cycle budget per test, reset included
	localparam int RESET_CYC   = 6;
	localparam int T1_CYC      = 6;
	localparam int T2_CYC      = 20;
	localparam int T3_CYC      = 16;
	localparam int T4_CYC      = 22;
	localparam int T5_CYC      = 20;
	localparam int CYCLE_LIMIT = 2 * (RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

	logic        CLK;
	logic        RST_N;
	logic        smpc_ce;
	pad_pins_u   pdr1_out;
	pad_pins_u   ddr1;
	pad_type_e   pad1_type;
	pad_in_t     pad1_in;
	pad_pins_u   pdr1_in;
	pad_pins_u   pdr2_out;
	pad_pins_u   ddr2;
	pad_type_e   pad2_type;
	pad_in_t     pad2_in;
	pad_pins_u   pdr2_in;

	// Expected handshake output per port
	pad_serial_t model1;
	pad_serial_t model2;
	pad_pins_u   exp1;
	pad_pins_u   exp2;
	logic        chk_en;

	int seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int tests;
	int err_mark;

	tb_clock_gen #(.PERIOD(100), .RST_CYC(4), .DRIVE_DLY(DRIVE_DLY)) clk_gen (
		.CLK   (CLK),
		.RST_N (RST_N)
	);

	smpc_pad_ports smpc_pad_ports_i (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce   (smpc_ce),
		.pdr1_out  (pdr1_out),
		.ddr1      (ddr1),
		.pad1_type (pad1_type),
		.pad1_in   (pad1_in),
		.pdr1_in   (pdr1_in),
		.pdr2_out  (pdr2_out),
		.ddr2      (ddr2),
		.pad2_type (pad2_type),
		.pad2_in   (pad2_in),
		.pdr2_in   (pdr2_in)
	);

	// Pin word as the pad should present it
	function automatic pad_pins_u expected_pins(
		input pad_pins_u   out,
		input pad_pins_u   dir,
		input pad_type_e   kind,
		input logic [15:0] btn,
		input pad_serial_t ser
	);
		pad_pins_u  r;
		logic [3:0] last;
		last = {btn[3], 3'b100};
		// Low only where driven and driven low
		r.raw = ~(dir.raw & ~out.raw);
		if (kind == pad_digital && dir.pins.th && !dir.pins.tr) begin
			r.pins.data = out.pins.th ? last : btn[15:12];
		end else if (kind == pad_digital && dir.pins.th && dir.pins.tr) begin
			if (out.pins.th) begin
				r.pins.data = out.pins.tr ? last : btn[11:8];
			end else begin
				r.pins.data = out.pins.tr ? btn[15:12] : btn[7:4];
			end
		end else if (kind == pad_wheel || kind == pad_mission || kind == pad_3d) begin
			r.pins.tl   = ser.tl;
			r.pins.data = ser.data;
		end
		return r;
	endfunction

	// Wheel nibble of handshake k, counted from 1
	function automatic logic [3:0] wheel_nib(input int k, input pad_in_t p);
		logic [3:0] n;
		case (k)
			1: n = `SMPC_PAD_ID_WHEEL_HI;
			2, 3: n = `SMPC_PAD_ID_WHEEL_LO;
			4: n = p.buttons[15:12];
			5: n = p.buttons[11:8];
			6: n = {1'b1, p.buttons[6:4]};
			7: n = 4'hF;
			8: n = p.axis_x[7:4] ^ `SMPC_PAD_AXIS_FLIP;
			9: n = p.axis_x[3:0];
			default: n = 4'h0;
		endcase
		return n;
	endfunction

	// Mission and 3D nibble of handshake k
	function automatic logic [3:0] analog_nib(input int k, input pad_in_t p, input logic is_3d);
		logic [3:0] n;
		case (k)
			1, 2: n = 4'h1;
			3: n = is_3d ? `SMPC_PAD_ID_3D : `SMPC_PAD_ID_MISSION;
			4: n = p.buttons[15:12];
			5: n = p.buttons[11:8];
			6: n = p.buttons[7:4];
			7: n = p.buttons[3:0];
			8: n = p.axis_x[7:4] ^ `SMPC_PAD_AXIS_FLIP;
			9: n = p.axis_x[3:0];
			10: n = p.axis_y[7:4] ^ `SMPC_PAD_AXIS_FLIP;
			11: n = p.axis_y[3:0];
			15: n = 4'h1;
			default: n = 4'h0;
		endcase
		return n;
	endfunction

	function automatic logic is_analog(input pad_type_e kind);
		return kind == pad_wheel || kind == pad_mission || kind == pad_3d;
	endfunction

	// State after TH=1,TR=1
	function automatic pad_serial_t idle_serial(input pad_type_e kind);
		pad_serial_t s;
		s.tl   = 1'b1;
		s.data = (kind == pad_wheel) ? 4'h0 : 4'h1;
		return s;
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#DRIVE_DLY;
	endtask

	// TH/TR levels on both ports, then one clock
	task automatic clock_levels(input logic [1:0] lv1, input logic [1:0] lv2);
		pdr1_out.pins.th = lv1[1];
		pdr1_out.pins.tr = lv1[0];
		pdr2_out.pins.th = lv2[1];
		pdr2_out.pins.tr = lv2[0];
		next_cycle();
	endtask

	task automatic randomize_inputs();
		logic [31:0] rnd;
		rnd = $random(seed);
		pad1_in = rnd;
		rnd = $random(seed);
		pad2_in = rnd;
		rnd = $random(seed);
		// Junk on the low pins, overridden or floated by the pad
		pdr1_out.raw[4:0] = rnd[4:0];
		pdr2_out.raw[4:0] = rnd[12:8];
	endtask

	// New types, TH/TR driven, abort level for one cycle
	task automatic restart_ports(input pad_type_e t1, input pad_type_e t2);
		pad1_type = t1;
		pad2_type = t2;
		ddr1.raw  = 7'h60;
		ddr2.raw  = 7'h60;
		smpc_ce   = 1'b1;
		clock_levels(2'b11, 2'b11);
		if (is_analog(t1)) begin
			model1 = idle_serial(t1);
		end
		if (is_analog(t2)) begin
			model2 = idle_serial(t2);
		end
	endtask

	task automatic report_test(input string name);
		next_cycle();
		tests = tests + 1;
		$display("Test %0d %s done, %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	// Sampled before the edge, so registered steps show one cycle late
	port1_pins: assert property (@(posedge CLK) disable iff (!chk_en) pdr1_in == exp1)
		else begin
			errors++;
			$display("Fail pdr1_in: got %h, expected %h", $sampled(pdr1_in), $sampled(exp1));
		end

	port2_pins: assert property (@(posedge CLK) disable iff (!chk_en) pdr2_in == exp2)
		else begin
			errors++;
			$display("Fail pdr2_in: got %h, expected %h", $sampled(pdr2_in), $sampled(exp2));
		end

	assign exp1 = expected_pins(pdr1_out, ddr1, pad1_type, pad1_in.buttons, model1);
	assign exp2 = expected_pins(pdr2_out, ddr2, pad2_type, pad2_in.buttons, model2);

	// Cycle count and run limit
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (chk_en) begin
			checks = checks + 2;
		end
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		int k;
		int code;
		int pass;
		seed         = 32'hca00_d640;
		tests        = 0;
		err_mark     = 0;
		chk_en       = 1'b0;
		smpc_ce      = 1'b0;
		pdr1_out.raw = '0;
		pdr2_out.raw = '0;
		ddr1.raw     = '0;
		ddr2.raw     = '0;
		pad1_type    = pad_digital;
		pad2_type    = pad_digital;
		pad1_in      = '0;
		pad2_in      = '0;
		// Handshake state right after reset
		model1       = {1'b1, 4'h0};
		model2       = {1'b1, 4'h0};
		@(posedge RST_N);
		chk_en = 1'b1;

		// Nothing driven, then analog types with enable low
		repeat (2) next_cycle();
		pad1_type = pad_wheel;
		pad2_type = pad_mission;
		ddr1.raw  = 7'h60;
		ddr2.raw  = 7'h60;
		clock_levels(2'b11, 2'b11);
		next_cycle();
		report_test("reset and readback");

		// Digital pad, TH/TR select then TH only
		pad1_type = pad_digital;
		pad2_type = pad_digital;
		smpc_ce   = 1'b1;
		for (pass = 0; pass < 2; pass++) begin
			randomize_inputs();
			ddr1.raw = 7'h60;
			ddr2.raw = 7'h60;
			for (code = 0; code < 4; code++) begin
				clock_levels(code[1:0], ~code[1:0]);
			end
			ddr1.raw = 7'h40;
			ddr2.raw = 7'h40;
			for (code = 0; code < 4; code++) begin
				clock_levels(code[1:0], ~code[1:0]);
			end
		end
		report_test("digital pad");

		// Wheel, nine steps then extra toggles
		randomize_inputs();
		restart_ports(pad_wheel, pad_digital);
		for (k = 1; k <= 9; k++) begin
			clock_levels({1'b0, k[0]}, {1'b0, k[0]});
			model1 = {k[0], wheel_nib(k, pad1_in)};
		end
		clock_levels(2'b00, 2'b00);
		clock_levels(2'b01, 2'b01);
		clock_levels(2'b00, 2'b00);
		report_test("wheel sequence");

		// Mission stalls after 13, 3D runs to 15
		randomize_inputs();
		restart_ports(pad_mission, pad_3d);
		for (k = 1; k <= 17; k++) begin
			clock_levels({1'b0, k[0]}, {1'b0, k[0]});
			if (k <= 13) begin
				model1 = {k[0], analog_nib(k, pad1_in, 1'b0)};
			end
			if (k <= 15) begin
				model2 = {k[0], analog_nib(k, pad2_in, 1'b1)};
			end
		end
		report_test("mission and 3D");

		randomize_inputs();
		restart_ports(pad_wheel, pad_mission);
		for (k = 1; k <= 3; k++) begin
			clock_levels({1'b0, k[0]}, {1'b0, k[0]});
			model1 = {k[0], wheel_nib(k, pad1_in)};
			model2 = {k[0], analog_nib(k, pad2_in, 1'b0)};
		end
		// Enable low, levels move but nothing is taken
		smpc_ce = 1'b0;
		for (k = 4; k <= 6; k++) begin
			clock_levels({1'b0, k[0]}, {1'b0, k[0]});
		end
		clock_levels(2'b11, 2'b11);
		clock_levels(2'b11, 2'b11);
		// Abort lands once enable is back
		smpc_ce = 1'b1;
		clock_levels(2'b11, 2'b11);
		model1 = idle_serial(pad1_type);
		model2 = idle_serial(pad2_type);
		for (k = 1; k <= 5; k++) begin
			clock_levels({1'b0, k[0]}, {1'b0, k[0]});
			model1 = {k[0], wheel_nib(k, pad1_in)};
			model2 = {k[0], analog_nib(k, pad2_in, 1'b0)};
		end
		report_test("enable and abort");

		chk_en = 1'b0;
		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog/pad_handshake.sv */
`timescale 1ns/1ps

`include "smpc_pad_cfg.svh"

module pad_handshake (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      smpc_ce,
	input  smpc_pad_pkg::pad_pins_u   pdr_out,
	input  smpc_pad_pkg::pad_type_e   pad_type,
	input  smpc_pad_pkg::pad_in_t     pad_in,
	output smpc_pad_pkg::pad_serial_t serial
);
	import smpc_pad_pkg::*;

	logic [`SMPC_PAD_STEP_W-1:0] step;
	logic [`SMPC_PAD_DATA_W-1:0] step_nib;
	logic [`SMPC_PAD_DATA_W-1:0] idle_nib;
	logic [`SMPC_PAD_DATA_W-1:0] x_hi;
	logic [`SMPC_PAD_DATA_W-1:0] x_lo;
	logic [`SMPC_PAD_DATA_W-1:0] y_hi;
	logic [`SMPC_PAD_DATA_W-1:0] y_lo;
	logic                        is_wheel;
	logic                        is_3d;
	logic                        is_analog;
	logic                        step_live;
	logic                        want_tr;
	logic                        level_ok;
	logic                        abort;

	assign is_wheel  = (pad_type == pad_wheel);
	assign is_3d     = (pad_type == pad_3d);
	assign is_analog = is_wheel || is_3d || (pad_type == pad_mission);

	// High axis nibbles get their sign flipped
	assign x_hi = pad_in.axis_x[7:4] ^ `SMPC_PAD_AXIS_FLIP;
	assign x_lo = pad_in.axis_x[3:0];
	assign y_hi = pad_in.axis_y[7:4] ^ `SMPC_PAD_AXIS_FLIP;
	assign y_lo = pad_in.axis_y[3:0];

	// Steps 0 and 1 both wait for TR high
	// then TR follows the step parity
	assign want_tr  = (step < 5'd2) ? 1'b1 : step[0];
	assign level_ok = !pdr_out.pins.th && (pdr_out.pins.tr == want_tr);
	assign abort    = pdr_out.pins.th && pdr_out.pins.tr;

	// Idle nibble is 0 for the wheel and 1 otherwise
	assign idle_nib = is_wheel ? 4'h0 : 4'h1;

	// Nibble table per type
	// step_live low once the sequence is used up
	always_comb begin
		step_nib  = '0;
		step_live = 1'b0;
		if (is_wheel) begin
			step_live = 1'b1;
			case (step)
				5'd0,
				5'd1: step_nib = `SMPC_PAD_ID_WHEEL_HI;
				5'd2,
				5'd3: step_nib = `SMPC_PAD_ID_WHEEL_LO;
				5'd4: step_nib = pad_in.buttons[15:12];
				5'd5: step_nib = pad_in.buttons[11:8];
				// Bit 7 of the buttons is not sent
				5'd6: step_nib = {1'b1, pad_in.buttons[6:4]};
				5'd7: step_nib = 4'hF;
				5'd8: step_nib = x_hi;
				5'd9: step_nib = x_lo;
				default: step_live = 1'b0;
			endcase
		end else if (is_analog) begin
			step_live = 1'b1;
			case (step)
				5'd0,
				5'd1,
				5'd2: step_nib = 4'h1;
				// Type ID tells mission and 3D apart
				5'd3: step_nib = is_3d ? `SMPC_PAD_ID_3D : `SMPC_PAD_ID_MISSION;
				5'd4: step_nib = pad_in.buttons[15:12];
				5'd5: step_nib = pad_in.buttons[11:8];
				5'd6: step_nib = pad_in.buttons[7:4];
				5'd7: step_nib = pad_in.buttons[3:0];
				5'd8: step_nib = x_hi;
				5'd9: step_nib = x_lo;
				5'd10: step_nib = y_hi;
				5'd11: step_nib = y_lo;
				// Trigger bytes sent as zero
				5'd12,
				5'd13: step_nib = 4'h0;
				// Mission stops after step 13
				5'd14: begin
					step_nib  = 4'h0;
					step_live = is_3d;
				end
				5'd15: step_nib = 4'h1;
				default: step_live = 1'b0;
			endcase
		end
	end

	// Handshake registers
	// Only analog types move
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			step        <= '0;
			serial.tl   <= 1'b1;
			serial.data <= '0;
		end else if (smpc_ce && is_analog) begin
			if (abort) begin
				// Host restarts the read
				step        <= '0;
				serial.tl   <= 1'b1;
				serial.data <= idle_nib;
			end else if (step_live && level_ok) begin
				serial.data <= step_nib;
				// TL echoes the TR level just seen
				serial.tl   <= want_tr;
				step        <= (step < 5'd2) ? 5'd2 : step + 5'd1;
			end
		end
	end

endmodule

/* verilog/pad_pin_mux.sv */
`timescale 1ns/1ps

`include "smpc_pad_cfg.svh"

module pad_pin_mux (
	input  smpc_pad_pkg::pad_pins_u   pdr_out,
	input  smpc_pad_pkg::pad_pins_u   ddr,
	input  smpc_pad_pkg::pad_type_e   pad_type,
	input  logic [`SMPC_PAD_BTN_W-1:0] buttons,
	input  smpc_pad_pkg::pad_serial_t serial,
	output smpc_pad_pkg::pad_pins_u   pdr_in
);
	import smpc_pad_pkg::*;

	logic [1:0] sel_dir;
	logic [1:0] sel_lvl;
	logic [3:0] nib_last;

	// TH/TR direction and level, as select codes
	assign sel_dir = {ddr.pins.th, ddr.pins.tr};
	assign sel_lvl = {pdr_out.pins.th, pdr_out.pins.tr};

	// Last nibble, L trigger plus fixed 100
	assign nib_last = {buttons[3], 3'b100};

	always_comb begin
		// Driven bits read back, undriven float high
		pdr_in.raw = (pdr_out.raw & ddr.raw) | ~ddr.raw;
		case (pad_type)
			pad_digital: begin
				if (sel_dir == 2'b10) begin
					// TH-only select
					pdr_in.pins.data = pdr_out.pins.th ? nib_last : buttons[15:12];
				end else if (sel_dir == 2'b11) begin
					// TH/TR select, four nibbles
					case (sel_lvl)
						2'b00: pdr_in.pins.data = buttons[7:4];
						2'b01: pdr_in.pins.data = buttons[15:12];
						2'b10: pdr_in.pins.data = buttons[11:8];
						default: pdr_in.pins.data = nib_last;
					endcase
				end
			end
			pad_wheel,
			pad_mission,
			pad_3d: begin
				// Handshake owns TL and nibble
				pdr_in.pins.tl   = serial.tl;
				pdr_in.pins.data = serial.data;
			end
			// Off and dual mission keep plain readback
			default: ;
		endcase
	end

endmodule

/* verilog/smpc_pad_pkg.sv */
`include "smpc_pad_cfg.svh"

package smpc_pad_pkg;

	// Peripheral type code, as set by the host
	// Mouse only reserves its code, no protocol behind it
	typedef enum logic [2:0] {
		pad_digital      = 3'd0,
		pad_off          = 3'd1,
		pad_wheel        = 3'd2,
		pad_mission      = 3'd3,
		pad_3d           = 3'd4,
		pad_dual_mission = 3'd5,
		pad_mouse        = 3'd6
	} pad_type_e;

	// Pad state from the host side
	// Axes are signed, centre at 0
	typedef struct packed {
		logic [`SMPC_PAD_BTN_W-1:0]  buttons;
		logic [`SMPC_PAD_AXIS_W-1:0] axis_x;
		logic [`SMPC_PAD_AXIS_W-1:0] axis_y;
	} pad_in_t;

	// Port pins by function
	typedef struct packed {
		logic                        th;
		logic                        tr;
		logic                        tl;
		logic [`SMPC_PAD_DATA_W-1:0] data;
	} pad_pins_t;

	// Same 7 bits, either as a mask word or as pins
	typedef union packed {
		logic [`SMPC_PAD_PIN_W-1:0] raw;
		pad_pins_t                  pins;
	} pad_pins_u;

	// Handshake output, TL plus nibble
	typedef struct packed {
		logic                        tl;
		logic [`SMPC_PAD_DATA_W-1:0] data;
	} pad_serial_t;

endpackage

/* verilog/smpc_pad_ports.sv */
`timescale 1ns/1ps

module smpc_pad_ports (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    smpc_ce,

	// Port 1
	input  smpc_pad_pkg::pad_pins_u pdr1_out,
	input  smpc_pad_pkg::pad_pins_u ddr1,
	input  smpc_pad_pkg::pad_type_e pad1_type,
	input  smpc_pad_pkg::pad_in_t   pad1_in,
	output smpc_pad_pkg::pad_pins_u pdr1_in,

	// Port 2
	input  smpc_pad_pkg::pad_pins_u pdr2_out,
	input  smpc_pad_pkg::pad_pins_u ddr2,
	input  smpc_pad_pkg::pad_type_e pad2_type,
	input  smpc_pad_pkg::pad_in_t   pad2_in,
	output smpc_pad_pkg::pad_pins_u pdr2_in
);
	import smpc_pad_pkg::*;

	pad_serial_t port1_serial;
	pad_serial_t port2_serial;

	// Port 1 handshake and pins
	pad_handshake port1_hs (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.smpc_ce  (smpc_ce),
		.pdr_out  (pdr1_out),
		.pad_type (pad1_type),
		.pad_in   (pad1_in),
		.serial   (port1_serial)
	);

	pad_pin_mux port1_mux (
		.pdr_out  (pdr1_out),
		.ddr      (ddr1),
		.pad_type (pad1_type),
		.buttons  (pad1_in.buttons),
		.serial   (port1_serial),
		.pdr_in   (pdr1_in)
	);

	// Port 2, fully independent of port 1
	pad_handshake port2_hs (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.smpc_ce  (smpc_ce),
		.pdr_out  (pdr2_out),
		.pad_type (pad2_type),
		.pad_in   (pad2_in),
		.serial   (port2_serial)
	);

	pad_pin_mux port2_mux (
		.pdr_out  (pdr2_out),
		.ddr      (ddr2),
		.pad_type (pad2_type),
		.buttons  (pad2_in.buttons),
		.serial   (port2_serial),
		.pdr_in   (pdr2_in)
	);

endmodule
